//--- build.f
source/memMonitorPkg.sv
source/uartRx.sv
source/uartTx.sv
source/wordMemory.sv
source/monitorControl.sv
source/memMonitorTop.sv
bench/memMonitorTb.sv

//--- Makefile
# Verilator build and run for the serial memory monitor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		--top-module memMonitorTb -f build.f -o VmemMonitorTb

# The log decides, a run without the pass line fails
run: compile
	./obj_dir/VmemMonitorTb | tee sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/memMonitorTb.sv
`default_nettype none
`timescale 1ns/100ps

module memMonitorTb;

    typedef logic [7:0] byteQueue_t [$];

    localparam logic [127:0] HexDigits = "0123456789abcdef";
    localparam int BitCycles = memMonitorPkg::ClocksPerBit;
    localparam int WaitLimit = 100 * memMonitorPkg::ClocksPerBit;    // Cycles per response wait

    logic clk;
    logic rstN;
    logic uartRxLine;
    logic uartTxLine;
    logic initDone;

    logic [memMonitorPkg::DataWidth-1:0] modelMem [memMonitorPkg::AddrCount];
    logic [7:0] sentBytes [$];     // Bytes decoded from uartTxLine
    logic [31:0] lfsrState;

    memMonitorTop dut_i (
        .clk(clk),
        .rstN(rstN),
        .uartRxLine(uartRxLine),
        .uartTxLine(uartTxLine),
        .initDone(initDone)
    );

    always #5 clk = ~clk;

    task automatic stopWithFailure();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkByte(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stopWithFailure();
        end
    endtask

    task automatic checkWord(input string name,
                             input logic [memMonitorPkg::DataWidth-1:0] actual,
                             input logic [memMonitorPkg::DataWidth-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stopWithFailure();
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic takeBit();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], takeBit()};
        end
        return value;
    endfunction

    function automatic logic [7:0] hexChar(input logic [3:0] nibble);
        int index;
        index = 15 - int'(nibble);      // First character sits in the top byte
        return HexDigits[8*index +: 8];
    endfunction

    function automatic logic isHexChar(input logic [7:0] ch);
        logic found;
        found = 1'b0;
        for (int n = 0; n < 16; n++) begin
            if (hexChar(4'(n)) == ch) found = 1'b1;
        end
        return found;
    endfunction

    function automatic logic [3:0] nibbleOfChar(input logic [7:0] ch);
        logic [3:0] found;
        found = '0;
        for (int n = 0; n < 16; n++) begin
            if (hexChar(4'(n)) == ch) found = 4'(n);
        end
        return found;
    endfunction

    // Full response line for one command against the model memory
    function automatic byteQueue_t expectedResponse(input logic [7:0] letter,
                                                    input logic [15:0] addr,
                                                    input logic [15:0] data);
        byteQueue_t resp;
        logic isWrite;
        logic [15:0] word;
        isWrite = (letter == "w");
        word = isWrite ? data : modelMem[addr];
        resp.push_back(isWrite ? "w" : "r");
        for (int i = 3; i >= 0; i--) begin
            resp.push_back(hexChar(addr[4*i +: 4]));
        end
        resp.push_back("=");
        for (int i = 3; i >= 0; i--) begin
            resp.push_back(hexChar(word[4*i +: 4]));
        end
        resp.push_back(8'h0d);
        resp.push_back(8'h0a);
        return resp;
    endfunction

    task automatic sendByte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};        // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uartRxLine <= frame[i];
            repeat (BitCycles - 1) @(posedge clk);
        end
    endtask

    task automatic waitForBytes(input int count);
        int cycles;
        cycles = 0;
        while (sentBytes.size() < count) begin
            @(negedge clk);
            cycles++;
            if (cycles > WaitLimit) begin
                $display("Timeout waiting for byte %0d of the response line", count);
                stopWithFailure();
            end
        end
    endtask

    task automatic waitForInitDone();
        int cycles;
        cycles = 0;
        while (initDone !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > memMonitorPkg::AddrCount + 64) begin
                $display("Timeout waiting for the memory clear to finish");
                stopWithFailure();
            end
        end
    endtask

    // The DUT drops input while sending so each typed character waits for its echo
    task automatic typeChar(input logic [7:0] ch, input int expectCount);
        sendByte(ch);
        waitForBytes(expectCount);
    endtask

    task automatic runCommand(input logic [7:0] letter, input logic [15:0] addr,
                              input logic [15:0] data);
        byteQueue_t expected;
        logic [15:0] readBack;
        logic isRead;
        expected = expectedResponse(letter, addr, data);
        isRead = (letter != "w");
        typeChar(letter, 1);
        for (int i = 0; i < 4; i++) begin
            typeChar(hexChar(addr[4*(3-i) +: 4]), (i == 3) ? 6 : i + 2);   // Last one brings "="
        end
        if (!isRead) begin
            for (int j = 0; j < 4; j++) begin
                typeChar(hexChar(data[4*(3-j) +: 4]), 7 + j);
            end
        end
        waitForBytes(expected.size());
        for (int k = 0; k < expected.size(); k++) begin
            // Read data digits are compared as one word below
            if (!(isRead && k >= 6 && k <= 9)) begin
                checkByte("uartTxLine byte", sentBytes[k], expected[k]);
            end
        end
        if (isRead) begin
            for (int k = 6; k <= 9; k++) begin
                if (!isHexChar(sentBytes[k])) begin
                    $display("Read data byte %0d is not a lowercase hex digit", k);
                    stopWithFailure();
                end
            end
            readBack = {nibbleOfChar(sentBytes[6]), nibbleOfChar(sentBytes[7]),
                        nibbleOfChar(sentBytes[8]), nibbleOfChar(sentBytes[9])};
            checkWord("read data", readBack, modelMem[addr]);
        end else begin
            modelMem[addr] = data;
        end
        sentBytes.delete();
    endtask

    // Serial decoder sampling on the falling clock edge
    initial begin
        logic [7:0] value;
        @(posedge rstN);
        forever begin
            @(negedge clk);
            if (uartTxLine === 1'b0) begin
                repeat (BitCycles / 2) @(negedge clk);
                if (uartTxLine !== 1'b0) begin
                    $display("Start bit on uartTxLine ended before its middle");
                    stopWithFailure();
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (BitCycles) @(negedge clk);
                    value[i] = uartTxLine;
                end
                repeat (BitCycles) @(negedge clk);
                if (uartTxLine !== 1'b1) begin
                    $display("Stop bit missing on uartTxLine");
                    stopWithFailure();
                end
                sentBytes.push_back(value);
            end
        end
    end

    initial begin
        repeat (400000) @(posedge clk);
        $display("Simulation ran past its cycle limit");
        stopWithFailure();
    end

    initial begin
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] base;
        logic [15:0] low;
        clk = 1'b0;
        rstN = 1'b0;
        uartRxLine = 1'b1;
        lfsrState = 32'h9888_1e6c;
        for (int i = 0; i < memMonitorPkg::AddrCount; i++) begin
            modelMem[i] = memMonitorPkg::DataWidth'(i);     // Clear pattern
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        waitForInitDone();

        repeat (4) begin
            addr = randomBits(16);
            runCommand("r", addr, 16'h0000);
        end

        addr = randomBits(16);
        data = randomBits(16);
        runCommand("w", addr, data);
        runCommand("r", addr, 16'h0000);

        runCommand("x", randomBits(16), 16'h0000);      // Unknown letter reads

        // Small block so neighbours of each write get read too
        base = randomBits(16);
        repeat (16) begin
            low = randomBits(3);
            addr = {base[15:3], low[2:0]};
            if (takeBit()) begin
                runCommand("w", addr, randomBits(16));
            end else begin
                runCommand("r", addr, 16'h0000);
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/memMonitorTop.sv
`default_nettype none
`timescale 1ns/100ps

module memMonitorTop (
    input  wire  clk,
    input  wire  rstN,
    input  wire  uartRxLine,
    output logic uartTxLine,
    output logic initDone
);

    logic [7:0] rxByte;
    logic       rxValid;
    logic [7:0] txByte;
    logic       txStart;
    logic       txBusy;

    memMonitorPkg::memCmd_t cmd;
    logic       cmdTrigger;
    logic       cmdReady;
    logic [memMonitorPkg::DataWidth-1:0] readData;
    logic       readDataValid;

    uartRx rx_i (
        .clk(clk),
        .rstN(rstN),
        .rxLine(uartRxLine),
        .rxByte(rxByte),
        .rxValid(rxValid)
    );

    uartTx tx_i (
        .clk(clk),
        .rstN(rstN),
        .txStart(txStart),
        .txByte(txByte),
        .txLine(uartTxLine),
        .txBusy(txBusy)
    );

    // Stands in for the external SDRAM controller
    wordMemory mem_i (
        .clk(clk),
        .rstN(rstN),
        .cmd(cmd),
        .cmdTrigger(cmdTrigger),
        .cmdReady(cmdReady),
        .readData(readData),
        .readDataValid(readDataValid)
    );

    monitorControl control_i (
        .clk(clk),
        .rstN(rstN),
        .rxByte(rxByte),
        .rxValid(rxValid),
        .txBusy(txBusy),
        .cmdReady(cmdReady),
        .readData(readData),
        .readDataValid(readDataValid),
        .cmd(cmd),
        .cmdTrigger(cmdTrigger),
        .txByte(txByte),
        .txStart(txStart),
        .initDone(initDone)
    );

endmodule

`default_nettype wire

//--- source/monitorControl.sv
`default_nettype none
`timescale 1ns/100ps

module monitorControl (
    input  wire                                 clk,
    input  wire                                 rstN,
    input  wire  [7:0]                          rxByte,
    input  wire                                 rxValid,
    input  wire                                 txBusy,
    input  wire                                 cmdReady,
    input  wire  [memMonitorPkg::DataWidth-1:0] readData,
    input  wire                                 readDataValid,
    output memMonitorPkg::memCmd_t              cmd,
    output logic                                cmdTrigger,
    output logic [7:0]                          txByte,
    output logic                                txStart,
    output logic                                initDone
);

    typedef enum logic [2:0] {
        StWaitLetter,
        StLetter,
        StAddress,
        StIssue,
        StWaitMem,
        StReadOut,
        StNewline
    } stage_t;

    stage_t stage;

    logic [31:0] outData;       // Left aligned, top byte goes out first
    logic [2:0]  outCount;
    logic [31:0] inData;        // Newest character in the low byte
    logic [2:0]  inCount;
    logic        inSuppress;    // Set while taking the command letter

    logic [memMonitorPkg::DataWidth-1:0] readWord;
    logic        readWordValid;
    logic        accepted;
    logic        isWrite;

    assign accepted = cmdTrigger && cmdReady;
    assign isWrite = (inData[7:0] == "w");

    // Four typed characters to one 16-bit word
    function automatic logic [15:0] wordFromHex(input logic [31:0] chars);
        return {memMonitorPkg::nibbleFromHex(chars[31:24]),
                memMonitorPkg::nibbleFromHex(chars[23:16]),
                memMonitorPkg::nibbleFromHex(chars[15:8]),
                memMonitorPkg::nibbleFromHex(chars[7:0])};
    endfunction

    function automatic logic [31:0] hexFromWord(input logic [15:0] word);
        return {memMonitorPkg::hexFromNibble(word[15:12]),
                memMonitorPkg::hexFromNibble(word[11:8]),
                memMonitorPkg::hexFromNibble(word[7:4]),
                memMonitorPkg::hexFromNibble(word[3:0])};
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage <= StWaitLetter;
            cmd <= '0;
            cmdTrigger <= 1'b0;
            txByte <= '0;
            txStart <= 1'b0;
            initDone <= 1'b0;
            outData <= '0;
            outCount <= '0;
            inData <= '0;
            inCount <= '0;
            inSuppress <= 1'b0;
            readWord <= '0;
            readWordValid <= 1'b0;
        end else begin
            txStart <= 1'b0;
            if (accepted) cmdTrigger <= 1'b0;     // Reloaded below if another command follows

            if (!initDone) begin
                // Clear phase, every word gets its own address
                if (!cmdTrigger) begin
                    cmdTrigger <= 1'b1;
                    cmd.write <= 1'b1;
                    cmd.addr <= '0;
                    cmd.writeData <= '0;
                end else if (accepted) begin
                    if (cmd.addr == memMonitorPkg::AddrWidth'(memMonitorPkg::AddrCount - 1)) begin
                        initDone <= 1'b1;
                    end else begin
                        cmdTrigger <= 1'b1;
                        cmd.addr <= cmd.addr + 1'b1;
                        cmd.writeData <= cmd.addr + 1'b1;
                    end
                end
            end else begin
                if (readDataValid) begin
                    readWord <= readData;
                    readWordValid <= 1'b1;
                end

                // Nothing moves while a byte is on the wire
                if (!txStart && !txBusy) begin
                    if (outCount != 3'd0) begin
                        txByte <= outData[31:24];
                        txStart <= 1'b1;
                        outData <= {outData[23:0], 8'h00};
                        outCount <= outCount - 3'd1;
                    end else if (inCount != 3'd0) begin
                        if (rxValid) begin
                            inData <= {inData[23:0], rxByte};
                            inCount <= inCount - 3'd1;
                            if (!inSuppress) begin
                                txByte <= rxByte;       // Echo
                                txStart <= 1'b1;
                            end
                        end
                    end else begin
                        inSuppress <= 1'b0;
                        case (stage)
                            StWaitLetter: begin
                                inCount <= 3'd1;
                                inSuppress <= 1'b1;
                                stage <= StLetter;
                            end
                            StLetter: begin
                                // Anything but "w" is a read
                                cmd.write <= isWrite;
                                outData <= {(isWrite ? "w" : "r"), 24'h0};
                                outCount <= 3'd1;
                                inCount <= 3'd4;
                                stage <= StAddress;
                            end
                            StAddress: begin
                                outData <= {"=", 24'h0};
                                outCount <= 3'd1;
                                cmd.addr <= wordFromHex(inData);
                                if (cmd.write) inCount <= 3'd4;
                                stage <= StIssue;
                            end
                            StIssue: begin
                                if (cmd.write) begin
                                    cmd.writeData <= wordFromHex(inData);
                                end
                                cmdTrigger <= 1'b1;
                                readWordValid <= 1'b0;
                                stage <= StWaitMem;
                            end
                            StWaitMem: begin
                                // Hold until accepted, and for a read until the data is back
                                if (!cmdTrigger && (cmd.write || readWordValid)) begin
                                    stage <= StReadOut;
                                end
                            end
                            StReadOut: begin
                                if (!cmd.write) begin
                                    outData <= hexFromWord(readWord);
                                    outCount <= 3'd4;
                                end
                                stage <= StNewline;
                            end
                            default: begin
                                outData <= {8'h0d, 8'h0a, 16'h0};     // CR LF
                                outCount <= 3'd2;
                                stage <= StWaitLetter;
                            end
                        endcase
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/wordMemory.sv
`default_nettype none
`timescale 1ns/100ps

module wordMemory (
    input  wire                                 clk,
    input  wire                                 rstN,
    input  wire memMonitorPkg::memCmd_t         cmd,
    input  wire                                 cmdTrigger,
    output logic                                cmdReady,
    output logic [memMonitorPkg::DataWidth-1:0] readData,
    output logic                                readDataValid
);

    logic [memMonitorPkg::DataWidth-1:0] mem [memMonitorPkg::AddrCount];

    // One stage per cycle of read latency
    logic [memMonitorPkg::ReadLatency-1:0] validPipe;
    logic [memMonitorPkg::DataWidth-1:0] dataPipe [memMonitorPkg::ReadLatency];
    logic accept;
    logic readAccept;

    assign accept = cmdTrigger && cmdReady;
    assign readAccept = accept && !cmd.write;

    assign readDataValid = validPipe[memMonitorPkg::ReadLatency-1];
    assign readData = dataPipe[memMonitorPkg::ReadLatency-1];

    // Ready comes up once reset is released and stays up
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmdReady <= 1'b0;
        end else begin
            cmdReady <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && cmd.write) begin
            mem[cmd.addr] <= cmd.writeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= readAccept;
            for (int i = 1; i < memMonitorPkg::ReadLatency; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    // Data shifts every cycle so overlapping reads stay in order
    always_ff @(posedge clk) begin
        if (readAccept) begin
            dataPipe[0] <= mem[cmd.addr];
        end
        for (int i = 1; i < memMonitorPkg::ReadLatency; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
    end

endmodule

`default_nettype wire

//--- source/uartTx.sv
`default_nettype none
`timescale 1ns/100ps

module uartTx (
    input  wire        clk,
    input  wire        rstN,
    input  wire        txStart,
    input  wire  [7:0] txByte,
    output logic       txLine,
    output logic       txBusy
);

    logic [9:0] frame;          // Stop, data LSB first, start
    logic [3:0] bitsLeft;
    logic [memMonitorPkg::BitTimerWidth-1:0] timer;

    assign txLine = frame[0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frame <= '1;            // Idle high
            bitsLeft <= '0;
            timer <= '0;
            txBusy <= 1'b0;
        end else begin
            if (txStart && !txBusy) begin
                frame <= {1'b1, txByte, 1'b0};
                bitsLeft <= 4'd10;
                timer <= '0;
                txBusy <= 1'b1;
            end else if (txBusy) begin
                if (timer == memMonitorPkg::BitTimerMax) begin
                    timer <= '0;
                    frame <= {1'b1, frame[9:1]};    // Ones fill in behind the frame
                    bitsLeft <= bitsLeft - 4'd1;
                    // Busy ends with the stop bit
                    if (bitsLeft == 4'd1) begin
                        txBusy <= 1'b0;
                    end
                end else begin
                    timer <= timer + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/uartRx.sv
`default_nettype none
`timescale 1ns/100ps

module uartRx (
    input  wire        clk,
    input  wire        rstN,
    input  wire        rxLine,
    output logic [7:0] rxByte,
    output logic       rxValid
);

    typedef enum logic [1:0] {
        RxIdle,
        RxStart,
        RxData,
        RxStop
    } rxState_t;

    rxState_t state;
    logic [2:0] syncReg;        // Two sync flops plus one for edge detection
    logic [memMonitorPkg::BitTimerWidth-1:0] timer;
    logic [2:0] bitIndex;
    logic [7:0] shiftReg;
    logic lineSync;
    logic startEdge;

    assign lineSync = syncReg[1];
    assign startEdge = syncReg[2] && !syncReg[1];
    assign rxByte = shiftReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncReg <= 3'b111;      // Line idles high
            state <= RxIdle;
            timer <= '0;
            bitIndex <= '0;
            rxValid <= 1'b0;
        end else begin
            syncReg <= {syncReg[1:0], rxLine};
            rxValid <= 1'b0;

            case (state)
                RxIdle: begin
                    timer <= '0;
                    if (startEdge) state <= RxStart;
                end
                RxStart: begin
                    if (timer == memMonitorPkg::HalfBitMax) begin
                        // Middle of the start bit, a high line means a glitch
                        timer <= '0;
                        bitIndex <= '0;
                        state <= lineSync ? RxIdle : RxData;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RxData: begin
                    if (timer == memMonitorPkg::BitTimerMax) begin
                        timer <= '0;
                        bitIndex <= bitIndex + 3'd1;
                        if (bitIndex == 3'd7) state <= RxStop;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    if (timer == memMonitorPkg::BitTimerMax) begin
                        timer <= '0;
                        rxValid <= lineSync;    // Only a high stop bit completes the byte
                        state <= RxIdle;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == RxData && timer == memMonitorPkg::BitTimerMax) begin
            shiftReg <= {lineSync, shiftReg[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- source/memMonitorPkg.sv
`default_nettype none

package memMonitorPkg;

    localparam int AddrWidth = 16;
    localparam int DataWidth = 16;
    localparam int AddrCount = 65536;       // Words, also the clear sequence length

    localparam int ClocksPerBit = 16;       // Small for simulation, any value >= 4 works
    localparam int ReadLatency = 2;

    // Serial bit timer shared by both UART directions
    localparam int BitTimerWidth = $clog2(ClocksPerBit);
    localparam logic [BitTimerWidth-1:0] BitTimerMax = BitTimerWidth'(ClocksPerBit - 1);
    localparam logic [BitTimerWidth-1:0] HalfBitMax = BitTimerWidth'(ClocksPerBit / 2 - 1);

    typedef struct packed {
        logic                 write;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] writeData;
    } memCmd_t;

    // Lowercase ASCII hex digit for a nibble
    function automatic logic [7:0] hexFromNibble(input logic [3:0] nibble);
        if (nibble < 4'd10) begin
            return 8'h30 + {4'h0, nibble};
        end
        return 8'h57 + {4'h0, nibble};       // "a" minus ten
    endfunction

    // Uppercase letters fall into the digit branch and decode as garbage
    function automatic logic [3:0] nibbleFromHex(input logic [7:0] ch);
        logic [7:0] value;
        if (ch >= 8'h61) begin
            value = ch - 8'h57;
        end else begin
            value = ch - 8'h30;
        end
        return value[3:0];
    endfunction

endpackage

`default_nettype wire
